//--- verilog/trdb_settings.svh
/*
 * trace format widths, branch map capacity and resync limit
 */

`ifndef TRDB_SETTINGS_SVH
`define TRDB_SETTINGS_SVH

// core side widths
`define XLEN 32
`define INST_LEN 32
`define CAUSE_LEN 5
`define PRIV_LEN 2

// branch map, 31 entries fit a 5 bit count
`define BRANCH_MAP_LEN 31
`define BRANCH_COUNT_LEN 5

// packet output
`define PAYLOAD_LEN 72
`define P_LEN 4

// quiet tc instructions before a forced sync
`define RESYNC_MAX 16

`endif

//--- verilog/rv_isa_pkg.sv
/*
 * core side types: major opcodes, privilege levels, trap return words
 */

`include "trdb_settings.svh"

package rv_isa_pkg;

    // major opcodes, bits [6:0] of a 32 bit instruction
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } rv_opcode_e;

    // privilege levels, 2'b10 is reserved
    typedef enum logic [`PRIV_LEN-1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01,
        PRIV_M = 2'b11
    } rv_priv_e;

    // full encodings of the trap returns
    localparam logic [`INST_LEN-1:0] MRET_WORD = 32'h30200073;
    localparam logic [`INST_LEN-1:0] SRET_WORD = 32'h10200073;

endpackage

//--- verilog/trdb_pkg.sv
/*
 * encoder side types: packet formats and sync subformats
 */

package trdb_pkg;

    // packet format field, 2 bits wide
    // value 0 (differential branch format) is never produced here
    typedef enum logic [1:0] {
        F_BRANCH_FULL = 2'h1,
        F_ADDR_ONLY   = 2'h2,
        F_SYNC        = 2'h3
    } trdb_format_e;

    // subformat of a sync packet
    // start covers trace start, privilege change and resync
    typedef enum logic [1:0] {
        SF_START = 2'h0,
        SF_TRAP  = 2'h1
    } trdb_sync_subformat_e;

    // subformat is also carried with non sync packets,
    // where the receiver ignores it

endpackage

//--- verilog/trdb_itype_detector.sv
/*
 * tc instruction classifier: conditional branch, taken, uninferable jump
 */

`timescale 1ns/1ps

`include "trdb_settings.svh"

module trdb_itype_detector (
    input  logic [`INST_LEN-1:0] tc_inst_data_i,
    input  logic [`XLEN-1:0]     tc_pc_i,
    input  logic [`XLEN-1:0]     nc_pc_i,
    input  logic                 tc_exception_i,
    output logic                 branch_o,
    output logic                 branch_taken_o,
    output logic                 updiscon_o
);

    rv_isa_pkg::rv_opcode_e opcode;
    logic                   is_branch;
    logic                   is_jump;

    assign opcode = rv_isa_pkg::rv_opcode_e'(tc_inst_data_i[6:0]);

    always_comb begin
        is_branch = 1'b0;
        is_jump   = 1'b0;
        case (opcode)
            rv_isa_pkg::OPC_BRANCH: is_branch = 1'b1;
            // target held in a register, decoder cannot infer it
            rv_isa_pkg::OPC_JALR:   is_jump = 1'b1;
            // mret and sret return to a csr held epc
            rv_isa_pkg::OPC_SYSTEM: is_jump = (tc_inst_data_i == rv_isa_pkg::MRET_WORD) ||
                                              (tc_inst_data_i == rv_isa_pkg::SRET_WORD);
            // jal is pc relative, the decoder follows it from the image
            default:                is_jump = 1'b0;
        endcase
    end

    // a trapped instruction never reached its own target
    assign branch_o       = is_branch && !tc_exception_i;
    assign branch_taken_o = branch_o && (nc_pc_i != (tc_pc_i + `XLEN'd4));
    assign updiscon_o     = is_jump && !tc_exception_i;

endmodule

//--- verilog/trdb_branch_map.sv
/*
 * branch map: outcome bits of conditional branches and their count
 */

`timescale 1ns/1ps

`include "trdb_settings.svh"

module trdb_branch_map (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         valid_i,
    input  logic                         taken_i,
    input  logic                         flush_i,
    output logic [`BRANCH_MAP_LEN-1:0]   map_o,
    output logic [`BRANCH_COUNT_LEN-1:0] count_o
);

    logic [`BRANCH_MAP_LEN-1:0]   map_q;
    logic [`BRANCH_COUNT_LEN-1:0] count_q;

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            map_q   <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            // old map went out with the packet
            map_q   <= '0;
            count_q <= '0;
            if (valid_i) begin
                // tc branch opens the new map
                map_q[0] <= !taken_i;
                count_q  <= `BRANCH_COUNT_LEN'd1;
            end
        end else if (valid_i) begin
            // e-trace polarity, 1 means not taken
            map_q[count_q] <= !taken_i;
            count_q        <= count_q + 1'b1;
        end
    end

    // a full map always forces a flush before the next write
    assign map_o   = map_q;
    assign count_o = count_q;

endmodule

//--- verilog/trdb_priority.sv
/*
 * packet decision chain and resync counter
 */

`timescale 1ns/1ps

`include "trdb_settings.svh"

module trdb_priority (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               tc_fresh_i,
    input  logic                               lc_valid_i,
    input  logic                               lc_exception_i,
    input  logic                               lc_updiscon_i,
    input  rv_isa_pkg::rv_priv_e               tc_priv_i,
    input  rv_isa_pkg::rv_priv_e               lc_priv_i,
    input  logic [`BRANCH_COUNT_LEN-1:0]       branch_count_i,
    output logic                               emit_o,
    output trdb_pkg::trdb_format_e             format_o,
    output trdb_pkg::trdb_sync_subformat_e     subformat_o
);

    logic [$clog2(`RESYNC_MAX+1)-1:0] resync_cnt_q;
    logic                             hit;

    // first matching rule wins
    always_comb begin
        hit         = 1'b1;
        format_o    = trdb_pkg::F_SYNC;
        subformat_o = trdb_pkg::SF_START;
        if (!lc_valid_i) begin
            // nothing before tc, trace (re)starts here
            subformat_o = trdb_pkg::SF_START;
        end else if (lc_exception_i) begin
            subformat_o = trdb_pkg::SF_TRAP;
        end else if (tc_priv_i != lc_priv_i) begin
            subformat_o = trdb_pkg::SF_START;
        end else if (resync_cnt_q == `RESYNC_MAX) begin
            subformat_o = trdb_pkg::SF_START;
        end else if (lc_updiscon_i) begin
            // pending branches have to go with the address
            format_o = (branch_count_i == '0) ? trdb_pkg::F_ADDR_ONLY
                                              : trdb_pkg::F_BRANCH_FULL;
        end else if (branch_count_i == `BRANCH_MAP_LEN) begin
            format_o = trdb_pkg::F_BRANCH_FULL;
        end else begin
            hit = 1'b0;
        end
    end

    // only a freshly shifted tc is judged, once
    assign emit_o = tc_fresh_i && hit;

    // quiet instruction counter
    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            resync_cnt_q <= '0;
        end else if (emit_o) begin
            resync_cnt_q <= '0;
        end else if (tc_fresh_i) begin
            resync_cnt_q <= resync_cnt_q + 1'b1;
        end
    end

endmodule

//--- verilog/trdb_packet_emitter.sv
/*
 * payload packing, byte length and registered packet outputs
 */

`timescale 1ns/1ps

`include "trdb_settings.svh"

module trdb_packet_emitter (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               emit_i,
    input  trdb_pkg::trdb_format_e             format_i,
    input  trdb_pkg::trdb_sync_subformat_e     subformat_i,
    input  logic [`XLEN-1:0]                   tc_pc_i,
    input  logic [`XLEN-1:0]                   lc_pc_i,
    input  rv_isa_pkg::rv_priv_e               tc_priv_i,
    input  logic [`CAUSE_LEN-1:0]              lc_cause_i,
    input  logic                               lc_interrupt_i,
    input  logic [`BRANCH_COUNT_LEN-1:0]       branch_count_i,
    input  logic [`BRANCH_MAP_LEN-1:0]         branch_map_i,
    output logic                               packet_valid_o,
    output trdb_pkg::trdb_format_e             packet_format_o,
    output trdb_pkg::trdb_sync_subformat_e     packet_subformat_o,
    output logic [`P_LEN-1:0]                  packet_length_o,
    output logic [`PAYLOAD_LEN-1:0]            packet_payload_o
);

    logic [`PAYLOAD_LEN-1:0] payload_d;
    logic [`P_LEN-1:0]       length_d;

    // fields from bit 0 upward, upper bits stay zero
    always_comb begin
        payload_d = '0;
        length_d  = '0;
        case (format_i)
            trdb_pkg::F_SYNC: begin
                if (subformat_i == trdb_pkg::SF_TRAP) begin
                    // 44 bits, pc of the trapping instruction
                    payload_d = `PAYLOAD_LEN'({lc_pc_i, lc_cause_i, lc_interrupt_i,
                                              tc_priv_i, subformat_i, format_i});
                    length_d  = `P_LEN'd6;
                end else begin
                    // 38 bits
                    payload_d = `PAYLOAD_LEN'({tc_pc_i, tc_priv_i, subformat_i, format_i});
                    length_d  = `P_LEN'd5;
                end
            end
            trdb_pkg::F_ADDR_ONLY: begin
                // 34 bits
                payload_d = `PAYLOAD_LEN'({tc_pc_i, format_i});
                length_d  = `P_LEN'd5;
            end
            trdb_pkg::F_BRANCH_FULL: begin
                // 70 bits, map bit 0 is the oldest branch
                payload_d = `PAYLOAD_LEN'({tc_pc_i, branch_map_i, branch_count_i, format_i});
                length_d  = `P_LEN'd9;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            packet_valid_o     <= 1'b0;
            packet_format_o    <= trdb_pkg::F_SYNC;
            packet_subformat_o <= trdb_pkg::SF_START;
            packet_length_o    <= '0;
            packet_payload_o   <= '0;
        end else begin
            // one cycle pulse, fields hold until the next packet
            packet_valid_o <= emit_i;
            if (emit_i) begin
                packet_format_o    <= format_i;
                packet_subformat_o <= subformat_i;
                packet_length_o    <= length_d;
                packet_payload_o   <= payload_d;
            end
        end
    end

endmodule

//--- verilog/trace_debugger.sv
/*
 * trace encoder top: strobe clocked nc/tc/lc stages and sub-module wiring
 */

`timescale 1ns/1ps

`include "trdb_settings.svh"

module trace_debugger (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           trace_enable_i,
    input  logic                           inst_valid_i,
    input  logic [`INST_LEN-1:0]           inst_data_i,
    input  logic [`XLEN-1:0]               pc_i,
    input  rv_isa_pkg::rv_priv_e           priv_lvl_i,
    input  logic                           exception_i,
    input  logic                           interrupt_i,
    input  logic [`CAUSE_LEN-1:0]          cause_i,
    output logic                           packet_valid_o,
    output trdb_pkg::trdb_format_e         packet_format_o,
    output trdb_pkg::trdb_sync_subformat_e packet_subformat_o,
    output logic [`P_LEN-1:0]              packet_length_o,
    output logic [`PAYLOAD_LEN-1:0]        packet_payload_o
);

    // stage control
    logic                 nc_valid, tc_valid, lc_valid;
    logic                 tc_fresh;
    logic                 nc_exception, tc_exception, lc_exception;
    logic                 lc_updiscon;
    // stage payload
    logic [`INST_LEN-1:0] nc_inst_data, tc_inst_data;
    logic [`XLEN-1:0]     nc_pc, tc_pc, lc_pc;
    rv_isa_pkg::rv_priv_e nc_priv, tc_priv, lc_priv;
    logic                 nc_interrupt, tc_interrupt, lc_interrupt;
    logic [`CAUSE_LEN-1:0] nc_cause, tc_cause, lc_cause;
    // sub-module nets
    logic                 branch, branch_taken, updiscon, emit;
    logic [`BRANCH_MAP_LEN-1:0]     branch_map;
    logic [`BRANCH_COUNT_LEN-1:0]   branch_count;
    trdb_pkg::trdb_format_e         format;
    trdb_pkg::trdb_sync_subformat_e subformat;

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            {nc_valid, tc_valid, lc_valid, tc_fresh} <= '0;
            {nc_exception, tc_exception, lc_exception, lc_updiscon} <= '0;
        end else if (!trace_enable_i) begin
            // pipeline drains, next enable starts cold
            {nc_valid, tc_valid, lc_valid, tc_fresh} <= '0;
        end else begin
            // tc judged once, right after it arrives
            tc_fresh <= inst_valid_i && nc_valid;
            if (inst_valid_i) begin
                {lc_valid, tc_valid, nc_valid} <= {tc_valid, nc_valid, 1'b1};
                {lc_exception, tc_exception, nc_exception} <=
                    {tc_exception, nc_exception, exception_i};
                lc_updiscon <= tc_valid && updiscon;
            end
        end
    end

    // shifts on every strobe, valid bits above say what is real
    always_ff @(posedge clk_i) begin
        if (inst_valid_i) begin
            {tc_inst_data, nc_inst_data} <= {nc_inst_data, inst_data_i};
            {lc_pc, tc_pc, nc_pc} <= {tc_pc, nc_pc, pc_i};
            lc_priv <= tc_priv;
            tc_priv <= nc_priv;
            nc_priv <= priv_lvl_i;
            {lc_interrupt, tc_interrupt, nc_interrupt} <= {tc_interrupt, nc_interrupt, interrupt_i};
            {lc_cause, tc_cause, nc_cause} <= {tc_cause, nc_cause, cause_i};
        end
    end

    trdb_itype_detector i_trdb_itype_detector (
        .tc_inst_data_i(tc_inst_data), .tc_pc_i(tc_pc), .nc_pc_i(nc_pc),
        .tc_exception_i(tc_exception), .branch_o(branch),
        .branch_taken_o(branch_taken), .updiscon_o(updiscon)
    );

    // emit hands the old map to the emitter and restarts it
    trdb_branch_map i_trdb_branch_map (
        .clk_i(clk_i), .rst_ni(rst_ni), .valid_i(tc_fresh && branch),
        .taken_i(branch_taken), .flush_i(emit), .map_o(branch_map), .count_o(branch_count)
    );

    trdb_priority i_trdb_priority (
        .clk_i(clk_i), .rst_ni(rst_ni), .tc_fresh_i(tc_fresh), .lc_valid_i(lc_valid),
        .lc_exception_i(lc_exception), .lc_updiscon_i(lc_updiscon), .tc_priv_i(tc_priv),
        .lc_priv_i(lc_priv), .branch_count_i(branch_count), .emit_o(emit),
        .format_o(format), .subformat_o(subformat)
    );

    trdb_packet_emitter i_trdb_packet_emitter (
        .clk_i(clk_i), .rst_ni(rst_ni), .emit_i(emit), .format_i(format),
        .subformat_i(subformat), .tc_pc_i(tc_pc), .lc_pc_i(lc_pc), .tc_priv_i(tc_priv),
        .lc_cause_i(lc_cause), .lc_interrupt_i(lc_interrupt),
        .branch_count_i(branch_count), .branch_map_i(branch_map),
        .packet_valid_o(packet_valid_o), .packet_format_o(packet_format_o),
        .packet_subformat_o(packet_subformat_o), .packet_length_o(packet_length_o),
        .packet_payload_o(packet_payload_o)
    );

endmodule

//--- sim/tb_trace_debugger.sv
/*
 * testbench for the trace encoder: lfsr driven instruction stream,
 * stage model with expected packet queue, packet checker and timeout
 */

`timescale 1ns/1ps

`include "trdb_settings.svh"

module tb_trace_debugger;

    localparam int NUM_RANDOM  = 60;
    localparam int NUM_BRANCH  = 40;
    localparam int NUM_QUIET   = 20;
    localparam int NUM_OFF     = 30;
    localparam int TOTAL_INSTS = 2 * NUM_RANDOM + NUM_BRANCH + NUM_QUIET + NUM_OFF;
    // each instruction takes at most a strobe and three idle cycles
    localparam int PLANNED_CYCLES = 16 + 4 * TOTAL_INSTS + 100;
    localparam int CYCLE_LIMIT    = 4 * PLANNED_CYCLES;

    logic clk = 1'b0;
    logic rst_n;
    logic trace_en;
    logic inst_valid;
    logic [`INST_LEN-1:0] inst_data;
    logic [`XLEN-1:0] pc;
    rv_isa_pkg::rv_priv_e priv_lvl;
    logic exception, interrupt;
    logic [`CAUSE_LEN-1:0] cause;
    logic packet_valid;
    trdb_pkg::trdb_format_e packet_format;
    trdb_pkg::trdb_sync_subformat_e packet_subformat;
    logic [`P_LEN-1:0] packet_length;
    logic [`PAYLOAD_LEN-1:0] packet_payload;

    // model stages, index 0 nc, 1 tc, 2 lc
    logic st_valid[3], st_exc[3], st_intr[3], st_upd[3], st_br[3], st_tk[3];
    logic [31:0] st_pc[3];
    logic [1:0] st_priv[3];
    logic [4:0] st_cause[3];
    logic [30:0] map_m = '0;
    logic [4:0] count_m = '0;
    int resync_m = 0;
    logic [79:0] exp_q[$];
    // cycle in which each expected packet has to show up
    int due_q[$];
    logic [31:0] lfsr = 32'habce;
    logic [31:0] cur_pc = 32'h0000_1000;
    logic [1:0] cur_priv = 2'b11;
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    trace_debugger i_dut (
        .clk_i(clk), .rst_ni(rst_n), .trace_enable_i(trace_en), .inst_valid_i(inst_valid),
        .inst_data_i(inst_data), .pc_i(pc), .priv_lvl_i(priv_lvl), .exception_i(exception),
        .interrupt_i(interrupt), .cause_i(cause), .packet_valid_o(packet_valid),
        .packet_format_o(packet_format), .packet_subformat_o(packet_subformat),
        .packet_length_o(packet_length), .packet_payload_o(packet_payload)
    );

    always #5 clk = ~clk;

    // galois lfsr, taps 32,22,2,1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // packet layout, fields from bit 0 upward
    function automatic logic [79:0] expected_packet(input logic [1:0] fmt, input logic [1:0] sf);
        logic [71:0] p;
        logic [3:0] len;
        p = '0;
        p[1:0] = fmt;
        if (fmt == 2'd3 && sf == 2'd1) begin
            p[3:2] = sf;
            p[5:4] = st_priv[1];
            p[6] = st_intr[2];
            p[11:7] = st_cause[2];
            p[43:12] = st_pc[2];
            len = 4'd6;
        end else if (fmt == 2'd3) begin
            p[3:2] = sf;
            p[5:4] = st_priv[1];
            p[37:6] = st_pc[1];
            len = 4'd5;
        end else if (fmt == 2'd2) begin
            p[33:2] = st_pc[1];
            len = 4'd5;
        end else begin
            p[6:2] = count_m;
            p[37:7] = map_m;
            p[69:38] = st_pc[1];
            len = 4'd9;
        end
        return {fmt, sf, len, p};
    endfunction

    // judge the model tc, nc already holds its successor
    task automatic evaluate_tc();
        logic emit, br, tk;
        logic [1:0] fmt, sf;
        br = st_br[1] && !st_exc[1];
        tk = br && st_tk[1];
        emit = 1'b1;
        fmt = 2'd3;
        sf = 2'd0;
        if (!st_valid[2]) sf = 2'd0;
        else if (st_exc[2]) sf = 2'd1;
        else if (st_priv[1] != st_priv[2]) sf = 2'd0;
        else if (resync_m == `RESYNC_MAX) sf = 2'd0;
        else if (st_upd[2]) fmt = (count_m == 5'd0) ? 2'd2 : 2'd1;
        else if (count_m == 5'd31) fmt = 2'd1;
        else emit = 1'b0;
        if (emit) begin
            exp_q.push_back(expected_packet(fmt, sf));
            // strobe edge, then the edge that registers the packet
            due_q.push_back(cycles + 2);
            resync_m = 0;
            map_m = '0;
            count_m = '0;
        end else begin
            resync_m++;
        end
        if (br) begin
            map_m[count_m] = !tk;
            count_m = count_m + 5'd1;
        end
    endtask

    // kinds: 1 taken, 2 not taken, 3 jalr, 4 mret, 5 trap, 6 priv change, else plain
    task automatic send_inst(input int kind, input int gap);
        logic [31:0] word, next_pc, rnd;
        logic exc, intr, is_br, is_upd;
        logic [4:0] cs;
        take_bits(8, rnd);
        word = {25'h0, 7'b0110011};
        next_pc = cur_pc + 32'd4;
        exc = 1'b0;
        intr = 1'b0;
        is_br = 1'b0;
        is_upd = 1'b0;
        cs = '0;
        case (kind)
            1: begin
                word = {25'h0, 7'b1100011};
                next_pc = cur_pc + 32'h40;
                is_br = 1'b1;
            end
            2: begin
                word = {25'h0, 7'b1100011};
                is_br = 1'b1;
            end
            3: begin
                word = {25'h0, 7'b1100111};
                next_pc = {16'h0, rnd[7:0], 8'h0};
                is_upd = 1'b1;
            end
            4: begin
                word = 32'h3020_0073;
                next_pc = {16'h1, rnd[7:0], 8'h0};
                is_upd = 1'b1;
            end
            5: begin
                exc = 1'b1;
                intr = rnd[5];
                cs = rnd[4:0];
                next_pc = 32'h0000_0100;
                // a trapping branch or jalr records nothing of its own
                if (rnd[6]) begin
                    word = {25'h0, 7'b1100011};
                    is_br = 1'b1;
                end else if (rnd[7]) begin
                    word = {25'h0, 7'b1100111};
                    is_upd = 1'b1;
                end
            end
            default: ;
        endcase
        inst_valid = 1'b1;
        inst_data = word;
        pc = cur_pc;
        priv_lvl = rv_isa_pkg::rv_priv_e'(cur_priv);
        exception = exc;
        interrupt = intr;
        cause = cs;
        if (trace_en) begin
            for (int s = 2; s > 0; s--) begin
                st_valid[s] = st_valid[s-1];
                st_pc[s] = st_pc[s-1];
                st_priv[s] = st_priv[s-1];
                st_exc[s] = st_exc[s-1];
                st_intr[s] = st_intr[s-1];
                st_cause[s] = st_cause[s-1];
                st_upd[s] = st_upd[s-1];
                st_br[s] = st_br[s-1];
                st_tk[s] = st_tk[s-1];
            end
            st_valid[0] = 1'b1;
            st_pc[0] = cur_pc;
            st_priv[0] = cur_priv;
            st_exc[0] = exc;
            st_intr[0] = intr;
            st_cause[0] = cs;
            st_upd[0] = is_upd && !exc;
            st_br[0] = is_br;
            st_tk[0] = (kind == 1);
            if (st_valid[1]) evaluate_tc();
        end
        cur_pc = next_pc;
        // privilege of the following instructions
        if (kind == 6) begin
            cur_priv = (cur_priv == 2'b11) ? 2'b00 : (cur_priv == 2'b01 ? 2'b11 : 2'b01);
        end
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_value(input string name, input logic [71:0] got, input logic [71:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic random_phase(input int n);
        logic [31:0] k, g;
        for (int i = 0; i < n; i++) begin
            take_bits(3, k);
            take_bits(2, g);
            send_inst(int'(k), int'(g));
        end
    endtask

    // packets are stable between edges
    always @(negedge clk) begin
        logic [79:0] e;
        int due;
        if (rst_n && packet_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected packet at %0t ns while none was predicted", $time);
            end else begin
                e = exp_q.pop_front();
                due = due_q.pop_front();
                check_value("packet_valid_o cycle", 72'(cycles), 72'(due));
                check_value("packet_format_o", 72'(packet_format), 72'(e[79:78]));
                check_value("packet_subformat_o", 72'(packet_subformat), 72'(e[77:76]));
                check_value("packet_length_o", 72'(packet_length), 72'(e[75:72]));
                check_value("packet_payload_o", packet_payload, e[71:0]);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, packets still pending: %0d", cycles, exp_q.size());
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] b;
        for (int s = 0; s < 3; s++) st_valid[s] = 1'b0;
        rst_n = 1'b0;
        trace_en = 1'b1;
        inst_valid = 1'b0;
        inst_data = '0;
        pc = '0;
        priv_lvl = rv_isa_pkg::PRIV_M;
        exception = 1'b0;
        interrupt = 1'b0;
        cause = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle(2);
        random_phase(NUM_RANDOM);
        // full branch map, back to back
        for (int i = 0; i < NUM_BRANCH; i++) begin
            take_bits(1, b);
            send_inst(1 + int'(b[0]), 0);
        end
        // quiet run for the resync counter
        for (int i = 0; i < NUM_QUIET; i++) send_inst(0, 0);
        idle(3);
        trace_en = 1'b0;
        for (int s = 0; s < 3; s++) st_valid[s] = 1'b0;
        random_phase(NUM_OFF);
        idle(2);
        trace_en = 1'b1;
        idle(1);
        random_phase(NUM_RANDOM);
        while (exp_q.size() != 0) @(posedge clk);
        idle(4);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/trdb_pkg.sv
verilog/trdb_itype_detector.sv
verilog/trdb_branch_map.sv
verilog/trdb_priority.sv
verilog/trdb_packet_emitter.sv
verilog/trace_debugger.sv
sim/tb_trace_debugger.sv

//--- Makefile
# Verilator build and regression run for the trace encoder

VERILATOR ?= verilator
TOP       ?= tb_trace_debugger
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(wildcard verilog/*.sv verilog/*.svh sim/*.sv) $(FILELIST)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Regression failed" $(LOG); then \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
